/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* logic/alu.sv */
module alu (
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    input  cpuPkg::aluOp_t op,
    output cpuPkg::word_t  result,
    output cpuPkg::flags_t flags
);

    cpuPkg::word_t opX, opY;
    logic          carryIn;
    logic          isArith;
    logic [32:0]   sum;

    // subtraction runs as x + ~y + 1, so carry out is NOT borrow
    always_comb begin
        opX     = a;
        opY     = b;
        carryIn = 1'b0;
        isArith = 1'b1;
        case (op)
            cpuPkg::AluSub, cpuPkg::AluCmp: begin
                opY     = ~b;
                carryIn = 1'b1;
            end
            cpuPkg::AluRsb: begin
                opX     = b;
                opY     = ~a;
                carryIn = 1'b1;
            end
            cpuPkg::AluAdd:  opY = b;
            cpuPkg::AluInc4: opY = 32'd4;
            default:         isArith = 1'b0;
        endcase
    end

    assign sum = {1'b0, opX} + {1'b0, opY} + {32'b0, carryIn};

    always_comb begin
        case (op)
            cpuPkg::AluAnd:   result = a & b;
            cpuPkg::AluEor:   result = a ^ b;
            cpuPkg::AluOrr:   result = a | b;
            cpuPkg::AluMov:   result = b;
            cpuPkg::AluBic:   result = a & ~b;
            cpuPkg::AluMvn:   result = ~b;
            cpuPkg::AluPassA: result = a;
            default:          result = sum[31:0];
        endcase
    end

    assign flags.carry    = isArith && sum[32];
    assign flags.zero     = (result == '0);
    assign flags.negative = result[31];
    // same-sign operands giving an opposite-sign sum
    assign flags.overflow = isArith && (opX[31] == opY[31]) && (sum[31] != opX[31]);

    always_comb begin
        assert (!$isunknown(op));
    end

endmodule

/* logic/conditionUnit.sv */
module conditionUnit (
    input  logic              Clk,
    input  logic              reset,
    input  logic              flagLoad,
    input  cpuPkg::flags_t    aluFlags,
    input  cpuPkg::condCode_t cond,
    output logic              condPass
);

    cpuPkg::flags_t flagReg;
    logic           c, z, n, v;

    always_ff @(posedge Clk) begin
        if (reset)
            flagReg <= '0;
        else if (flagLoad)
            flagReg <= aluFlags;
    end

    assign c = flagReg.carry;
    assign z = flagReg.zero;
    assign n = flagReg.negative;
    assign v = flagReg.overflow;

    always_comb begin
        case (cond)
            4'h0:    condPass = z;              // EQ
            4'h1:    condPass = !z;             // NE
            4'h2:    condPass = c;              // CS
            4'h3:    condPass = !c;             // CC
            4'h4:    condPass = n;              // MI
            4'h5:    condPass = !n;             // PL
            4'h6:    condPass = v;              // VS
            4'h7:    condPass = !v;             // VC
            4'h8:    condPass = c && !z;        // HI
            4'h9:    condPass = !c || z;        // LS
            4'hA:    condPass = (n == v);       // GE
            4'hB:    condPass = (n != v);       // LT
            4'hC:    condPass = !z && (n == v); // GT
            4'hD:    condPass = z || (n != v);  // LE
            4'hE:    condPass = 1'b1;           // AL
            default: condPass = 1'b0;           // never
        endcase
    end

endmodule

/* logic/controlUnit.sv */
module controlUnit (
    input  logic                Clk,
    input  logic                reset,
    input  logic                moc,
    input  cpuPkg::instrClass_t instrClass,
    input  cpuPkg::aluOp_t      aluOp,
    input  logic                updateFlags,
    input  logic                condPass,
    output cpuPkg::ctrlWord_t   ctrl
);

    cpuPkg::cuState_t state, nextState;
    logic             fetchWait, nextFetchWait;  // second half of StFetch

    always_ff @(posedge Clk) begin
        if (reset) begin
            state     <= cpuPkg::StFetch;
            fetchWait <= 1'b0;
        end else begin
            state     <= nextState;
            fetchWait <= nextFetchWait;
        end
    end

    always_comb begin
        ctrl          = '0;
        ctrl.aluOp    = cpuPkg::AluPassA;
        nextState     = state;
        nextFetchWait = 1'b0;
        case (state)
            cpuPkg::StFetch: begin
                ctrl.regASel = cpuPkg::SelPc;
                if (!fetchWait) begin
                    ctrl.marLoad  = 1'b1;  // MAR <- PC
                    nextFetchWait = 1'b1;
                end else begin
                    // PC+4 lands together with the instruction word
                    ctrl.memValid = 1'b1;
                    ctrl.aluOp    = cpuPkg::AluInc4;
                    ctrl.regCSel  = cpuPkg::SelPc;
                    ctrl.irLoad   = moc;
                    ctrl.rfLoad   = moc;
                    nextFetchWait = !moc;
                    if (moc)
                        nextState = cpuPkg::StDecode;
                end
            end
            cpuPkg::StDecode: begin
                // ALU is idle here, so stage the store data in the MDR
                ctrl.regASel = cpuPkg::SelRd;
                ctrl.mdrLoad = condPass && (instrClass == cpuPkg::ClsStore);
                if (!condPass)
                    nextState = cpuPkg::StFetch;
                else begin
                    case (instrClass)
                        cpuPkg::ClsData:   nextState = cpuPkg::StExec;
                        cpuPkg::ClsLoad:   nextState = cpuPkg::StMemAddr;
                        cpuPkg::ClsStore:  nextState = cpuPkg::StMemAddr;
                        cpuPkg::ClsBranch: nextState = cpuPkg::StBranch;
                        default:           nextState = cpuPkg::StFetch;
                    endcase
                end
            end
            cpuPkg::StExec: begin
                ctrl.aluOp    = aluOp;
                ctrl.aluBSel  = cpuPkg::BReg;  // top swaps in the immediate
                ctrl.regCSel  = cpuPkg::SelRd;
                ctrl.rfLoad   = (aluOp != cpuPkg::AluCmp);
                ctrl.flagLoad = updateFlags;
                nextState     = cpuPkg::StFetch;
            end
            cpuPkg::StMemAddr: begin
                ctrl.aluOp   = cpuPkg::AluAdd;
                ctrl.aluBSel = cpuPkg::BOffset;
                ctrl.marLoad = 1'b1;
                nextState = (instrClass == cpuPkg::ClsLoad) ? cpuPkg::StMemRead
                                                            : cpuPkg::StMemWrite;
            end
            cpuPkg::StMemRead: begin
                ctrl.memValid   = 1'b1;
                ctrl.mdrFromMem = 1'b1;
                ctrl.mdrLoad    = moc;
                if (moc)
                    nextState = cpuPkg::StLoadBack;
            end
            cpuPkg::StMemWrite: begin
                ctrl.memValid = 1'b1;
                ctrl.memWrite = 1'b1;
                if (moc)
                    nextState = cpuPkg::StFetch;
            end
            cpuPkg::StLoadBack: begin
                ctrl.regCSel   = cpuPkg::SelRd;
                ctrl.rfFromMdr = 1'b1;
                ctrl.rfLoad    = 1'b1;
                nextState      = cpuPkg::StFetch;
            end
            cpuPkg::StBranch: begin
                ctrl.regASel = cpuPkg::SelPc;  // already holds address + 4
                ctrl.aluOp   = cpuPkg::AluAdd;
                ctrl.aluBSel = cpuPkg::BBranch;
                ctrl.regCSel = cpuPkg::SelPc;
                ctrl.rfLoad  = 1'b1;
                nextState    = cpuPkg::StFetch;
            end
            default: nextState = cpuPkg::StFetch;
        endcase
    end

    // a bus request is held until the memory completes it
    memHold: assert property (@(posedge Clk) disable iff (reset)
        ctrl.memValid && !moc |=> ctrl.memValid);

endmodule

/* logic/cpuPkg.sv */
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  regIdx_t;
    typedef logic [3:0]  condCode_t;
    typedef logic [3:0]  aluOp_t;
    typedef logic [2:0]  instrClass_t;
    typedef logic [1:0]  regSel_t;
    typedef logic [1:0]  bSel_t;

    localparam regIdx_t PcIdx = 4'd15;

    // same values as the opcode field
    localparam aluOp_t AluAnd   = 4'd0;
    localparam aluOp_t AluEor   = 4'd1;
    localparam aluOp_t AluSub   = 4'd2;
    localparam aluOp_t AluRsb   = 4'd3;
    localparam aluOp_t AluAdd   = 4'd4;
    localparam aluOp_t AluPassA = 4'd5;  // internal only
    localparam aluOp_t AluInc4  = 4'd6;  // internal only
    localparam aluOp_t AluCmp   = 4'd10;
    localparam aluOp_t AluOrr   = 4'd12;
    localparam aluOp_t AluMov   = 4'd13;
    localparam aluOp_t AluBic   = 4'd14;
    localparam aluOp_t AluMvn   = 4'd15;

    localparam instrClass_t ClsData   = 3'd0;
    localparam instrClass_t ClsLoad   = 3'd1;
    localparam instrClass_t ClsStore  = 3'd2;
    localparam instrClass_t ClsBranch = 3'd3;
    localparam instrClass_t ClsNone   = 3'd4;

    localparam regSel_t SelRn = 2'd0;
    localparam regSel_t SelRd = 2'd1;
    localparam regSel_t SelPc = 2'd2;

    localparam bSel_t BReg    = 2'd0;
    localparam bSel_t BImm    = 2'd1;
    localparam bSel_t BOffset = 2'd2;
    localparam bSel_t BBranch = 2'd3;

    // instruction field positions
    localparam int CondMsb   = 31;
    localparam int CondLsb   = 28;
    localparam int FmtMsb    = 27;
    localparam int FmtLsb    = 25;
    localparam int IBit      = 25;
    localparam int PBit      = 24;
    localparam int LinkBit   = 24;
    localparam int OpMsb     = 24;
    localparam int OpLsb     = 21;
    localparam int UBit      = 23;
    localparam int ByteBit   = 22;
    localparam int WBit      = 21;
    localparam int SBit      = 20;
    localparam int LBit      = 20;
    localparam int RnMsb     = 19;
    localparam int RnLsb     = 16;
    localparam int RdMsb     = 15;
    localparam int RdLsb     = 12;
    localparam int ShiftMsb  = 11;
    localparam int ShiftLsb  = 4;
    localparam int RotLsb    = 8;
    localparam int RmMsb     = 3;
    localparam int RmLsb     = 0;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
        logic overflow;
    } flags_t;

    typedef enum logic [2:0] {
        StFetch, StDecode, StExec, StMemAddr, StMemRead, StMemWrite, StLoadBack, StBranch
    } cuState_t;

    typedef struct packed {
        logic    rfLoad;
        logic    irLoad;
        logic    marLoad;
        logic    mdrLoad;
        logic    flagLoad;
        regSel_t regASel;
        regSel_t regCSel;
        bSel_t   aluBSel;
        logic    mdrFromMem;
        logic    rfFromMdr;   // load write-back path
        logic    memValid;
        logic    memWrite;
        aluOp_t  aluOp;       // decoded or internal op as picked by the FSM
    } ctrlWord_t;

    typedef struct packed {
        logic  valid;   // MOV
        logic  write;   // inverse of R_W
        word_t address;
        word_t writeData;
    } memReq_t;

endpackage

/* logic/cpuTop.sv */
module cpuTop #(
    parameter cpuPkg::word_t ResetVector = 32'h0
) (
    input  logic            Clk,
    input  logic            reset,
    output cpuPkg::memReq_t memReq,
    input  logic            moc,
    input  cpuPkg::word_t   readData
);

    cpuPkg::ctrlWord_t   ctrl;
    cpuPkg::word_t       ir, mar, mdr;
    cpuPkg::word_t       dataA, dataB, aluB, aluResult, rfWriteData;
    cpuPkg::word_t       immVal, offsetVal, branchVal;
    cpuPkg::regIdx_t     readA, writeIdx;
    cpuPkg::instrClass_t instrClass;
    cpuPkg::aluOp_t      decodedOp;
    cpuPkg::flags_t      aluFlags;
    cpuPkg::bSel_t       bSel;
    logic                updateFlags, condPass;

    always_ff @(posedge Clk) begin
        if (ctrl.irLoad)
            ir <= readData;
        if (ctrl.marLoad)
            mar <= aluResult;
        if (ctrl.mdrLoad)
            mdr <= ctrl.mdrFromMem ? readData : aluResult;
    end

    always_comb begin
        case (ctrl.regASel)
            cpuPkg::SelRd: readA = ir[cpuPkg::RdMsb:cpuPkg::RdLsb];
            cpuPkg::SelPc: readA = cpuPkg::PcIdx;
            default:       readA = ir[cpuPkg::RnMsb:cpuPkg::RnLsb];
        endcase
        case (ctrl.regCSel)
            cpuPkg::SelRn: writeIdx = ir[cpuPkg::RnMsb:cpuPkg::RnLsb];
            cpuPkg::SelPc: writeIdx = cpuPkg::PcIdx;
            default:       writeIdx = ir[cpuPkg::RdMsb:cpuPkg::RdLsb];
        endcase
    end

    assign immVal    = {24'b0, ir[7:0]};
    assign offsetVal = {20'b0, ir[11:0]};
    assign branchVal = {{6{ir[23]}}, ir[23:0], 2'b00} + 32'd4;  // PC is only +4 here

    // data ops take their operand form from the I bit
    assign bSel = (ctrl.aluBSel == cpuPkg::BReg && ir[cpuPkg::IBit]) ? cpuPkg::BImm
                                                                      : ctrl.aluBSel;

    always_comb begin
        case (bSel)
            cpuPkg::BImm:    aluB = immVal;
            cpuPkg::BOffset: aluB = offsetVal;
            cpuPkg::BBranch: aluB = branchVal;
            default:         aluB = dataB;
        endcase
    end

    assign rfWriteData = ctrl.rfFromMdr ? mdr : aluResult;

    assign memReq = '{valid: ctrl.memValid, write: ctrl.memWrite,
                      address: mar, writeData: mdr};

    controlUnit cu0 (
        .Clk(Clk), .reset(reset), .moc(moc), .instrClass(instrClass), .aluOp(decodedOp),
        .updateFlags(updateFlags), .condPass(condPass), .ctrl(ctrl)
    );

    instrDecoder dec0 (
        .instr(ir), .instrClass(instrClass), .aluOp(decodedOp), .updateFlags(updateFlags)
    );

    registerFile #(.ResetVector(ResetVector)) rf0 (
        .Clk(Clk), .reset(reset), .readA(readA), .readB(ir[cpuPkg::RmMsb:cpuPkg::RmLsb]),
        .writeIdx(writeIdx), .writeData(rfWriteData), .writeEn(ctrl.rfLoad),
        .dataA(dataA), .dataB(dataB)
    );

    alu alu0 (
        .a(dataA), .b(aluB), .op(ctrl.aluOp), .result(aluResult), .flags(aluFlags)
    );

    conditionUnit cond0 (
        .Clk(Clk), .reset(reset), .flagLoad(ctrl.flagLoad), .aluFlags(aluFlags),
        .cond(ir[cpuPkg::CondMsb:cpuPkg::CondLsb]), .condPass(condPass)
    );

endmodule

/* logic/instrDecoder.sv */
module instrDecoder (
    input  cpuPkg::word_t       instr,
    output cpuPkg::instrClass_t instrClass,
    output cpuPkg::aluOp_t      aluOp,
    output logic                updateFlags
);

    cpuPkg::aluOp_t opField;
    logic           opSupported;

    assign opField = instr[cpuPkg::OpMsb:cpuPkg::OpLsb];

    always_comb begin
        case (opField)
            cpuPkg::AluAnd, cpuPkg::AluEor, cpuPkg::AluSub, cpuPkg::AluRsb,
            cpuPkg::AluAdd, cpuPkg::AluCmp, cpuPkg::AluOrr, cpuPkg::AluMov,
            cpuPkg::AluBic, cpuPkg::AluMvn: opSupported = 1'b1;
            default:                        opSupported = 1'b0;
        endcase
    end

    always_comb begin
        instrClass  = cpuPkg::ClsNone;  // anything unknown runs as a no-op
        aluOp       = cpuPkg::AluAdd;
        updateFlags = 1'b0;
        case (instr[cpuPkg::FmtMsb:cpuPkg::FmtLsb])
            3'b000: begin  // register operand, no shift
                if (opSupported && instr[cpuPkg::ShiftMsb:cpuPkg::ShiftLsb] == '0)
                    instrClass = cpuPkg::ClsData;
            end
            3'b001: begin  // unrotated 8-bit immediate
                if (opSupported && instr[cpuPkg::ShiftMsb:cpuPkg::RotLsb] == '0)
                    instrClass = cpuPkg::ClsData;
            end
            3'b010: begin
                // word access, pre-indexed, positive offset, no write-back
                if (instr[cpuPkg::PBit] && instr[cpuPkg::UBit] &&
                    !instr[cpuPkg::ByteBit] && !instr[cpuPkg::WBit])
                    instrClass = instr[cpuPkg::LBit] ? cpuPkg::ClsLoad : cpuPkg::ClsStore;
            end
            3'b101: begin
                if (!instr[cpuPkg::LinkBit])
                    instrClass = cpuPkg::ClsBranch;
            end
            default: instrClass = cpuPkg::ClsNone;
        endcase
        if (instrClass == cpuPkg::ClsData) begin
            aluOp       = opField;
            updateFlags = instr[cpuPkg::SBit] || (opField == cpuPkg::AluCmp);
        end
    end

endmodule

/* logic/registerFile.sv */
module registerFile #(
    parameter cpuPkg::word_t ResetVector = 32'h0
) (
    input  logic            Clk,
    input  logic            reset,
    input  cpuPkg::regIdx_t readA,
    input  cpuPkg::regIdx_t readB,
    input  cpuPkg::regIdx_t writeIdx,
    input  cpuPkg::word_t   writeData,
    input  logic            writeEn,
    output cpuPkg::word_t   dataA,
    output cpuPkg::word_t   dataB
);

    cpuPkg::word_t regs [16];
    logic [15:0]   writeSel;  // one-hot write decode

    assign writeSel = writeEn ? (16'b1 << writeIdx) : 16'b0;

    always_ff @(posedge Clk) begin
        for (int i = 0; i < 16; i++) begin
            if (reset)
                regs[i] <= (i == int'(cpuPkg::PcIdx)) ? ResetVector : '0;
            else if (writeSel[i])
                regs[i] <= writeData;
        end
    end

    assign dataA = regs[readA];
    assign dataB = regs[readB];

    pcAligned: assert property (@(posedge Clk) disable iff (reset)
        regs[cpuPkg::PcIdx][1:0] == 2'b00);

endmodule

/* src.f */
logic/cpuPkg.sv
logic/instrDecoder.sv
logic/controlUnit.sv
logic/registerFile.sv
logic/alu.sv
logic/conditionUnit.sv
logic/cpuTop.sv
tb/cpuTb.sv

/* tb/cpuTb.sv */
module cpuTb;

    localparam int CyclesPerWord = 60;
    localparam int ClkPeriod     = 4;

    logic            Clk;
    logic            reset;
    logic            moc;
    cpuPkg::word_t   readData;
    cpuPkg::memReq_t memReq;

    cpuPkg::word_t mem [cpuPkg::word_t];  // program and data words
    cpuPkg::word_t expAddr [$];
    cpuPkg::word_t expData [$];
    int            expIdx;
    int            wordCount;
    int            idleLeft;
    logic [31:0]   rngState;
    logic          loadDone;
    logic          storesDone;

    cpuTop #(.ResetVector(32'h0)) dut0 (
        .Clk(Clk), .reset(reset), .memReq(memReq), .moc(moc), .readData(readData)
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    function automatic logic [31:0] nextRandom(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkWord(input string name, input cpuPkg::word_t expected,
                             input cpuPkg::word_t actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %b actual %b", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic loadProgram();
        int            fd;
        string         line;
        byte           kind;
        cpuPkg::word_t a, b;
        fd = $fopen("tb/testdata_program.txt", "r");
        if (fd == 0)
            failRun("cannot open tb/testdata_program.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%c %h %h", kind, a, b) == 3) begin
                if (kind == "P") begin
                    mem[a] = b;
                    wordCount++;
                end else if (kind == "E") begin
                    expAddr.push_back(a);
                    expData.push_back(b);
                end
            end
        end
        $fclose(fd);
    endtask

    // one access completes here and moc goes high for a single cycle
    task automatic serveRequest();
        moc <= 1'b1;
        if (memReq.write) begin
            if (expIdx >= expAddr.size())
                failRun($sformatf("store to %h after the last expected one", memReq.address));
            checkWord("storeAddress", expAddr[expIdx], memReq.address);
            checkWord("storeData", expData[expIdx], memReq.writeData);
            mem[memReq.address] = memReq.writeData;
            expIdx++;
            if (expIdx == expAddr.size())
                storesDone <= 1'b1;
        end else begin
            // unwritten words read back as the inverted address
            readData <= mem.exists(memReq.address) ? mem[memReq.address] : ~memReq.address;
        end
    endtask

    // memory model samples the request as the DUT left it before this edge
    always @(posedge Clk) begin
        if (reset) begin
            moc      <= 1'b0;
            idleLeft <= 0;
        end else if (moc) begin
            moc      <= 1'b0;
            rngState = nextRandom(rngState);
            idleLeft <= int'(rngState[17:16]);  // 0 to 3 idle cycles
        end else if (memReq.valid) begin
            if (idleLeft != 0)
                idleLeft <= idleLeft - 1;
            else
                serveRequest();
        end
    end

    initial begin
        reset      = 1'b1;
        moc        = 1'b0;
        readData   = '0;
        expIdx     = 0;
        wordCount  = 0;
        idleLeft   = 0;
        rngState   = 32'h5f9b_2a84;
        loadDone   = 1'b0;
        storesDone = 1'b0;
        loadProgram();
        if (expAddr.size() == 0)
            failRun("no expected stores in the test data");
        loadDone = 1'b1;

        repeat (8) begin
            @(negedge Clk);
            checkBit("validInReset", 1'b0, memReq.valid);
        end
        @(posedge Clk);
        reset <= 1'b0;

        @(negedge Clk);
        checkBit("validAfterReset", 1'b0, memReq.valid);
        @(negedge Clk);
        checkBit("firstFetchValid", 1'b1, memReq.valid);
        checkBit("firstFetchRead", 1'b0, memReq.write);
        checkWord("firstFetchAddress", 32'h0, memReq.address);

        wait (storesDone);
        @(negedge Clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // watchdog sized from the number of program words
    initial begin
        wait (loadDone);
        #(wordCount * CyclesPerWord * ClkPeriod);
        $display("timeout, %0d of %0d expected stores seen", expIdx, expAddr.size());
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* tb/testdata_program.txt */
# P address word : program or data word at that address
# E address value : next expected store, in program order
P 00 E3A0105A
P 04 E3A0200F
P 08 E0013002
P 0C E5803200
P 10 E22140FF
P 14 E5804204
P 18 E0425001
P 1C E5805208
P 20 E2616010
P 24 E580620C
P 28 E0817002
P 2C E5807210
P 30 E38280A0
P 34 E5808214
P 38 E1C19002
P 3C E5809218
P 40 E1E0A002
P 44 E580A21C
# cmp r1 with 0x5A, then orr into r11 and r12 under codes 0 to 15
P 48 E351005A
P 4C 038BB001
P 50 138BB002
P 54 238BB004
P 58 338BB008
P 5C 438BB010
P 60 538BB020
P 64 638BB040
P 68 738BB080
P 6C 838CC001
P 70 938CC002
P 74 A38CC004
P 78 B38CC008
P 7C C38CC010
P 80 D38CC020
P 84 E38CC040
P 88 F38CC080
P 8C E580B220
P 90 E580C224
# ldr r13 from 0x300, str it at r1 + 0x2C6
P 94 E590D300
P 98 E581D2C6
# adds overflow, codes 0 to 7 again
P 9C E3A0B000
P A0 E09D300D
P A4 038BB001
P A8 138BB002
P AC 238BB004
P B0 338BB008
P B4 438BB010
P B8 538BB020
P BC 638BB040
P C0 738BB080
P C4 E580B228
# taken branch over a bad store, untaken beq, counted loop
P C8 EA000000
P CC E58012F0
P D0 0A000000
P D4 E580722C
P D8 E3A04000
P DC E3A05003
P E0 E2844007
P E4 E2555001
P E8 1AFFFFFC
P EC E5804230
P F0 EAFFFFFE
P 300 7FFFFFFF
E 200 0000000A
E 204 000000A5
E 208 FFFFFFB5
E 20C FFFFFFB6
E 210 00000069
E 214 000000AF
E 218 00000050
E 21C FFFFFFF0
E 220 000000A5
E 224 00000066
E 320 7FFFFFFF
E 228 0000005A
E 22C 00000069
E 230 00000015
